// ==== bench/perf_stimulus.txt ====
// one run per line, hex: base stride beats bursts id err_flag
// followed by expected aw_cnt w_cnt b_cnt err_cnt
00000 00020 04 0003 5 0   3 0c 3 0
01000 00100 01 0005 a 1   5 05 5 5
// address wraps past the top of the 20-bit space
ff000 00800 08 0004 3 0   4 20 4 0
12340 00000 10 0002 f 1   2 20 2 2
// empty setups give no traffic
00000 00010 00 0004 1 0   0 00 0 0
00400 00040 03 0000 2 1   0 00 0 0
// stride of minus 0x40
80000 fffc0 02 0006 7 1   6 0c 6 6
00010 00004 20 0001 0 0   1 20 1 0

// ==== all.f ====
+incdir+source
source/perf_pkg.sv
source/chan_reg.sv
source/burst_counter.sv
source/perf_ctrl_fsm.sv
source/perf_stats.sv
source/perf_regs.sv
source/axi_perf_top.sv
bench/axi_perf_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := axi_perf_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/10ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) --Mdir $(OBJ_DIR)
PASS_TEXT  := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/axi_perf_tb.sv ====
`timescale 1ns/10ps

`include "perf_defines.svh"

module axi_perf_tb;

  import perf_pkg::*;

  localparam int NUM_RUNS = 8;
  localparam int COLS     = 10;

  logic                     clk;
  logic                     rst_n;
  logic                     reg_wr;
  logic                     reg_rd;
  logic [`PERF_REG_A_W-1:0] reg_addr;
  logic [`PERF_CNT_W-1:0]   reg_wdata;
  logic [`PERF_CNT_W-1:0]   reg_rdata;
  logic                     reg_rvalid;
  logic                     aw_valid;
  aw_beat_t                 aw;
  logic                     aw_ready = 1'b0;
  logic                     w_valid;
  w_beat_t                  w;
  logic                     w_ready = 1'b0;
  logic                     b_valid = 1'b0;
  b_resp_t                  b = '0;
  logic                     b_ready;

  logic [31:0]             stim [0:NUM_RUNS*COLS-1];
  logic                    stim_loaded = 1'b0;
  logic [`PERF_ADDR_W-1:0] cur_base;
  logic [`PERF_ADDR_W-1:0] cur_stride;
  logic [7:0]              cur_beats;
  logic [15:0]             cur_num;
  logic [`PERF_ID_W-1:0]   cur_id;
  logic                    cur_err;
  int                      aw_start;
  int                      w_start;
  int                      b_start;
  int                      errors;
  int                      checks;

  // owned by the memory responder
  int       seed = 83;
  int       aw_seen = 0;
  int       w_seen = 0;
  int       wlast_seen = 0;
  int       b_seen = 0;
  int       mem_errors = 0;
  int       mem_checks = 0;
  logic     b_taken = 1'b0;
  logic     aw_stall = 1'b0;
  logic     w_stall = 1'b0;
  aw_beat_t aw_held;
  w_beat_t  w_held;

  axi_perf_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t: %s read %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR %0t: %s", $time, what);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    check_true(reg_rvalid === 1'b0, "reg_rvalid was high with no read pending");
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    check_true(reg_rvalid === 1'b1, "reg_rvalid did not follow reg_rd by one cycle");
    data   = reg_rdata;
    reg_rd = 1'b0;
  endtask

  task automatic clear_counts();
    logic [31:0] v;
    write_reg(`PERF_REG_CLEAR, 32'd1);
    for (int i = 0; i < 5; i++) begin
      read_reg(`PERF_REG_AW_CNT + 8'(i), v);
      check_eq(v, 32'd0, $sformatf("register %0d after clear", `PERF_REG_AW_CNT + 8'(i)));
    end
  endtask

  task automatic run_one(input int n);
    logic [31:0] v;
    int          row;
    row        = n * COLS;
    cur_base   = stim[row][`PERF_ADDR_W-1:0];
    cur_stride = stim[row+1][`PERF_ADDR_W-1:0];
    cur_beats  = stim[row+2][7:0];
    cur_num    = stim[row+3][15:0];
    cur_id     = stim[row+4][`PERF_ID_W-1:0];
    cur_err    = stim[row+5][0];
    clear_counts();
    // file columns 0 to 4 follow the register map from BASE to ID
    for (int i = 0; i < 5; i++) begin
      write_reg(`PERF_REG_BASE + 8'(i), stim[row+i]);
    end
    for (int i = 0; i < 5; i++) begin
      read_reg(`PERF_REG_BASE + 8'(i), v);
      check_eq(v, stim[row+i],
               $sformatf("config register %0d, run %0d", `PERF_REG_BASE + 8'(i), n));
    end
    aw_start = aw_seen;
    w_start  = w_seen;
    b_start  = b_seen;
    write_reg(`PERF_REG_START, 32'd1);
    if (stim[row+6] != 32'd0) begin
      read_reg(`PERF_REG_IDLE, v);
      check_eq(v, 32'd0, $sformatf("IDLE just after start, run %0d", n));
      // second start lands inside the run
      write_reg(`PERF_REG_START, 32'd1);
    end
    v = 32'd0;
    while (v != 32'd1) begin
      read_reg(`PERF_REG_IDLE, v);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(`PERF_REG_AW_CNT + 8'(i), v);
      check_eq(v, stim[row+6+i],
               $sformatf("stats register %0d, run %0d", `PERF_REG_AW_CNT + 8'(i), n));
    end
    read_reg(`PERF_REG_CYCLES, v);
    check_true(v != 32'd0, $sformatf("CYCLES stayed zero over run %0d", n));
    check_eq(32'(aw_seen - aw_start), stim[row+6], $sformatf("bursts at memory, run %0d", n));
    check_eq(32'(w_seen - w_start), stim[row+7], $sformatf("beats at memory, run %0d", n));
    check_eq(32'(b_seen - b_start), stim[row+8], $sformatf("responses at memory, run %0d", n));
  endtask

  // --------------------
  // memory responder
  // --------------------
  always @(negedge clk) begin : responder
    logic [31:0] rnd;
    int          k;
    int          idx;
    int          beat;
    aw_beat_t    exp_aw;
    w_beat_t     exp_w;
    if (b_taken) begin
      b_valid = 1'b0;
      b_taken = 1'b0;
    end
    // stalled payloads must sit still
    if (aw_stall) begin
      mem_checks++;
      assert (aw_valid === 1'b1 && aw === aw_held) else begin
        mem_errors++;
        $display("ERROR %0t: AW changed while stalled, got %h held %h", $time, aw, aw_held);
      end
    end
    if (w_stall) begin
      mem_checks++;
      assert (w_valid === 1'b1 && w === w_held) else begin
        mem_errors++;
        $display("ERROR %0t: W changed while stalled, got %h held %h", $time, w, w_held);
      end
    end
    rnd      = $random(seed);
    aw_ready = (rnd[1:0] != 2'b00);
    w_ready  = (rnd[3:2] != 2'b00);
    // a response only once both address and last beat are in
    if (!b_valid && aw_seen > b_seen && wlast_seen > b_seen && rnd[4]) begin
      b_valid = 1'b1;
      b.bid   = cur_id;
      b.bresp = cur_err ? 2'b10 : 2'b00;
    end
    if (b_valid && b_ready === 1'b1) begin
      b_taken = 1'b1;
      b_seen++;
    end
    if (aw_valid === 1'b1 && aw_ready) begin
      k              = aw_seen - aw_start;
      exp_aw.awaddr  = cur_base + 20'(k) * cur_stride;
      exp_aw.awid    = cur_id;
      exp_aw.awlen   = cur_beats - 8'd1;
      exp_aw.awsize  = 3'd1;
      exp_aw.awburst = 2'b01;
      mem_checks++;
      assert (aw === exp_aw) else begin
        mem_errors++;
        $display("ERROR %0t: AW of burst %0d is %h, expected %h", $time, k, aw, exp_aw);
      end
      assert (k < int'(cur_num) && b_seen - b_start == k) else begin
        mem_errors++;
        $display("burst %0d address came early or beyond the configured count", k);
      end
      aw_seen++;
    end
    if (w_valid === 1'b1 && w_ready) begin
      idx = w_seen - w_start;
      k   = (cur_beats == 8'd0) ? 0 : idx / int'(cur_beats);
      beat = (cur_beats == 8'd0) ? 0 : idx % int'(cur_beats);
      exp_w.wdata = {8'(k), 8'(beat)};
      exp_w.wstrb = 2'b11;
      exp_w.wlast = (beat == int'(cur_beats) - 1);
      mem_checks++;
      assert (w === exp_w) else begin
        mem_errors++;
        $display("ERROR %0t: W beat %0d of burst %0d is %h, expected %h",
                 $time, beat, k, w, exp_w);
      end
      assert (k < int'(cur_num)) else begin
        mem_errors++;
        $display("write beat arrived beyond the configured burst count");
      end
      w_seen++;
      if (w.wlast) begin
        wlast_seen++;
      end
    end
    aw_stall = (aw_valid === 1'b1) && !aw_ready;
    w_stall  = (w_valid === 1'b1) && !w_ready;
    aw_held  = aw;
    w_held   = w;
  end

  initial begin : watchdog
    int limit;
    wait (stim_loaded);
    limit = 2000;
    for (int i = 0; i < NUM_RUNS; i++) begin
      limit = limit + 40 * int'(stim[i*COLS+2] * stim[i*COLS+3]);
    end
    repeat (limit) @(posedge clk);
    $display("timeout: the runs did not finish within %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    $readmemh("bench/perf_stimulus.txt", stim);
    stim_loaded = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_eq(32'({aw_valid, w_valid, b_ready, reg_rvalid}), 32'd0, "valid outputs in reset");
    rst_n = 1'b1;
    for (int n = 0; n < NUM_RUNS; n++) begin
      run_one(n);
    end
    clear_counts();
    $display("checks %0d, errors %0d (register side %0d, memory side %0d)",
             checks + mem_checks, errors + mem_errors, errors, mem_errors);
    if (errors + mem_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/axi_perf_top.sv ====
`timescale 1ns/10ps

`include "perf_defines.svh"

module axi_perf_top (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     reg_wr,
  input  logic                     reg_rd,
  input  logic [`PERF_REG_A_W-1:0] reg_addr,
  input  logic [`PERF_CNT_W-1:0]   reg_wdata,
  output logic [`PERF_CNT_W-1:0]   reg_rdata,
  output logic                     reg_rvalid,

  output logic                     aw_valid,
  output perf_pkg::aw_beat_t       aw,
  input  logic                     aw_ready,
  output logic                     w_valid,
  output perf_pkg::w_beat_t        w,
  input  logic                     w_ready,
  input  logic                     b_valid,
  input  perf_pkg::b_resp_t        b,
  output logic                     b_ready
);

  import perf_pkg::*;

  run_cfg_t     cfg;
  perf_counts_t counts;
  aw_beat_t     aw_next;
  w_beat_t      w_next;
  logic         start_req;
  logic         clear;
  logic         run_go;
  logic         run_done;
  logic         running;
  logic         aw_load;
  logic         aw_free;
  logic         w_load;
  logic         w_free;

  perf_regs regs0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_rvalid(reg_rvalid),
    .running   (running),
    .counts    (counts),
    .cfg       (cfg),
    .start_req (start_req),
    .clear     (clear)
  );

  perf_ctrl_fsm ctrl0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_req(start_req),
    .run_done (run_done),
    .run_go   (run_go),
    .running  (running)
  );

  burst_counter cnt0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .run_go  (run_go),
    .run_done(run_done),
    .aw_load (aw_load),
    .aw_next (aw_next),
    .aw_free (aw_free),
    .w_load  (w_load),
    .w_next  (w_next),
    .w_free  (w_free),
    .b_valid (b_valid),
    .b_ready (b_ready)
  );

  // --------------------
  // channel registers
  // --------------------
  chan_reg #(.payload_t(aw_beat_t)) aw_reg0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (aw_load),
    .in_data  (aw_next),
    .in_ready (aw_free),
    .out_valid(aw_valid),
    .out_data (aw),
    .out_ready(aw_ready)
  );

  chan_reg #(.payload_t(w_beat_t)) w_reg0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (w_load),
    .in_data  (w_next),
    .in_ready (w_free),
    .out_valid(w_valid),
    .out_data (w),
    .out_ready(w_ready)
  );

  perf_stats stats0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (clear),
    .running(running),
    .aw_fire(aw_valid && aw_ready),
    .w_fire (w_valid && w_ready),
    .b_fire (b_valid && b_ready),
    .b_err  (b.bresp != 2'b00),
    .counts (counts)
  );

endmodule

// ==== source/perf_regs.sv ====
`timescale 1ns/10ps

`include "perf_defines.svh"

module perf_regs (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    reg_wr,
  input  logic                    reg_rd,
  input  logic [`PERF_REG_A_W-1:0] reg_addr,
  input  logic [`PERF_CNT_W-1:0]  reg_wdata,
  output logic [`PERF_CNT_W-1:0]  reg_rdata,
  output logic                    reg_rvalid,

  input  logic                    running,
  input  perf_pkg::perf_counts_t  counts,

  output perf_pkg::run_cfg_t      cfg,
  output logic                    start_req,
  output logic                    clear
);

  logic [`PERF_CNT_W-1:0] rd_mux;

  // --------------------
  // write side
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg        <= '0;
      start_req  <= 1'b0;
      clear      <= 1'b0;
      reg_rvalid <= 1'b0;
    end else begin
      // command strobes are dropped while a run is active
      start_req  <= reg_wr && (reg_addr == `PERF_REG_START) && !running;
      clear      <= reg_wr && (reg_addr == `PERF_REG_CLEAR) && !running;
      reg_rvalid <= reg_rd;
      if (reg_wr) begin
        case (reg_addr)
          `PERF_REG_BASE:   cfg.base   <= reg_wdata[`PERF_ADDR_W-1:0];
          `PERF_REG_STRIDE: cfg.stride <= reg_wdata[`PERF_ADDR_W-1:0];
          `PERF_REG_BEATS:  cfg.beats  <= reg_wdata[7:0];
          `PERF_REG_NUM:    cfg.num    <= reg_wdata[15:0];
          `PERF_REG_ID:     cfg.id     <= reg_wdata[`PERF_ID_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------
  // read side
  // --------------------
  always_comb begin
    case (reg_addr)
      `PERF_REG_IDLE:    rd_mux = `PERF_CNT_W'(!running);
      `PERF_REG_BASE:    rd_mux = `PERF_CNT_W'(cfg.base);
      `PERF_REG_STRIDE:  rd_mux = `PERF_CNT_W'(cfg.stride);
      `PERF_REG_BEATS:   rd_mux = `PERF_CNT_W'(cfg.beats);
      `PERF_REG_NUM:     rd_mux = `PERF_CNT_W'(cfg.num);
      `PERF_REG_ID:      rd_mux = `PERF_CNT_W'(cfg.id);
      `PERF_REG_AW_CNT:  rd_mux = counts.aw;
      `PERF_REG_W_CNT:   rd_mux = counts.w;
      `PERF_REG_B_CNT:   rd_mux = counts.b;
      `PERF_REG_ERR_CNT: rd_mux = counts.err;
      `PERF_REG_CYCLES:  rd_mux = counts.cycles;
      // start, clear and holes read as zero
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

// ==== source/perf_stats.sv ====
`timescale 1ns/10ps

`include "perf_defines.svh"

module perf_stats (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   clear,
  input  logic                   running,

  input  logic                   aw_fire,
  input  logic                   w_fire,
  input  logic                   b_fire,
  input  logic                   b_err,

  output perf_pkg::perf_counts_t counts
);

  localparam logic [`PERF_CNT_W-1:0] ONE = `PERF_CNT_W'(1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counts <= '0;
    end else if (clear) begin
      counts <= '0;
    end else begin
      if (aw_fire) begin
        counts.aw <= counts.aw + ONE;
      end
      if (w_fire) begin
        counts.w <= counts.w + ONE;
      end
      if (b_fire) begin
        counts.b <= counts.b + ONE;
      end
      // error counted only on an accepted response
      if (b_fire && b_err) begin
        counts.err <= counts.err + ONE;
      end
      if (running) begin
        counts.cycles <= counts.cycles + ONE;
      end
    end
  end

endmodule

// ==== source/perf_ctrl_fsm.sv ====
`timescale 1ns/10ps

module perf_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,

  input  logic start_req,
  input  logic run_done,

  output logic run_go,
  output logic running
);

  typedef enum logic {
    IDLE,
    RUNNING
  } state_t;

  state_t state;

  assign running = (state == RUNNING);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= IDLE;
      run_go <= 1'b0;
    end else begin
      run_go <= 1'b0;
      case (state)
        IDLE: begin
          if (start_req) begin
            // launch pulse lines up with the busy level
            run_go <= 1'b1;
            state  <= RUNNING;
          end
        end
        RUNNING: begin
          if (run_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== source/burst_counter.sv ====
`timescale 1ns/10ps

`include "perf_defines.svh"

module burst_counter (
  input  logic               clk,
  input  logic               rst_n,

  input  perf_pkg::run_cfg_t cfg,
  input  logic               run_go,
  output logic               run_done,

  output logic               aw_load,
  output perf_pkg::aw_beat_t aw_next,
  input  logic               aw_free,

  output logic               w_load,
  output perf_pkg::w_beat_t  w_next,
  input  logic               w_free,

  input  logic               b_valid,
  output logic               b_ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_AW,
    S_W,
    S_B
  } state_t;

  state_t                  state;
  logic [15:0]             burst_idx;
  logic [7:0]              beat_idx;
  logic [`PERF_ADDR_W-1:0] addr;
  logic                    cfg_empty;
  logic                    last_beat;
  logic                    last_burst;

  assign cfg_empty  = (cfg.beats == 8'd0) || (cfg.num == 16'd0);
  assign last_beat  = (beat_idx == cfg.beats - 8'd1);
  assign last_burst = (burst_idx == cfg.num - 16'd1);

  assign aw_load = (state == S_AW);
  assign w_load  = (state == S_W);
  assign b_ready = (state == S_B);

  // empty setup ends at once, otherwise on the final response
  assign run_done = (state == S_IDLE && run_go && cfg_empty) ||
                    (state == S_B && b_valid && last_burst);

  // --------------------
  // payload build
  // --------------------
  always_comb begin
    aw_next.awaddr  = addr;
    aw_next.awid    = cfg.id;
    aw_next.awlen   = cfg.beats - 8'd1;
    aw_next.awsize  = 3'($clog2(`PERF_DATA_W / 8));
    aw_next.awburst = 2'b01;

    // burst number high byte, beat number low byte
    w_next.wdata = `PERF_DATA_W'({burst_idx[7:0], beat_idx});
    w_next.wstrb = '1;
    w_next.wlast = last_beat;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      burst_idx <= '0;
      beat_idx  <= '0;
      addr      <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (run_go && !cfg_empty) begin
            addr      <= cfg.base;
            burst_idx <= '0;
            beat_idx  <= '0;
            state     <= S_AW;
          end
        end
        S_AW: begin
          if (aw_free) begin
            state <= S_W;
          end
        end
        S_W: begin
          if (w_free) begin
            beat_idx <= beat_idx + 8'd1;
            if (last_beat) begin
              beat_idx <= '0;
              state    <= S_B;
            end
          end
        end
        S_B: begin
          if (b_valid) begin
            if (last_burst) begin
              state <= S_IDLE;
            end else begin
              burst_idx <= burst_idx + 16'd1;
              addr      <= addr + cfg.stride;
              state     <= S_AW;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== source/chan_reg.sv ====
`timescale 1ns/10ps

module chan_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // free when empty or when the held beat leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload only moves on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== source/perf_pkg.sv ====
`include "perf_defines.svh"

package perf_pkg;

  // run setup as written through the register port
  typedef struct packed {
    logic [`PERF_ADDR_W-1:0] base;
    logic [`PERF_ADDR_W-1:0] stride;
    logic [7:0]              beats;
    logic [15:0]             num;
    logic [`PERF_ID_W-1:0]   id;
  } run_cfg_t;

  typedef struct packed {
    logic [`PERF_ADDR_W-1:0] awaddr;
    logic [`PERF_ID_W-1:0]   awid;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic [1:0]              awburst;
  } aw_beat_t;

  typedef struct packed {
    logic [`PERF_DATA_W-1:0]   wdata;
    logic [`PERF_DATA_W/8-1:0] wstrb;
    logic                      wlast;
  } w_beat_t;

  typedef struct packed {
    logic [`PERF_ID_W-1:0] bid;
    logic [1:0]            bresp;
  } b_resp_t;

  typedef struct packed {
    logic [`PERF_CNT_W-1:0] aw;
    logic [`PERF_CNT_W-1:0] w;
    logic [`PERF_CNT_W-1:0] b;
    logic [`PERF_CNT_W-1:0] err;
    logic [`PERF_CNT_W-1:0] cycles;
  } perf_counts_t;

endpackage

// ==== source/perf_defines.svh ====
`ifndef PERF_DEFINES_SVH
`define PERF_DEFINES_SVH

// AXI memory port widths
`define PERF_ADDR_W 20
`define PERF_DATA_W 16
`define PERF_ID_W 4

// register port and stat counter widths
`define PERF_CNT_W 32
`define PERF_REG_A_W 8

// --------------------
// register map
// --------------------
`define PERF_REG_START 8'd0
`define PERF_REG_IDLE 8'd1
`define PERF_REG_CLEAR 8'd2
`define PERF_REG_BASE 8'd3
`define PERF_REG_STRIDE 8'd4
`define PERF_REG_BEATS 8'd5
`define PERF_REG_NUM 8'd6
`define PERF_REG_ID 8'd7
`define PERF_REG_AW_CNT 8'd8
`define PERF_REG_W_CNT 8'd9
`define PERF_REG_B_CNT 8'd10
`define PERF_REG_ERR_CNT 8'd11
`define PERF_REG_CYCLES 8'd12

`endif
